// File: source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// pc held during reset
// first request goes to reset pc + 4
`define CPU_RESET_PC 32'h1BFFFFFC

// data and address width
`define CPU_XLEN 32

// general registers, r0 reads as zero
`define CPU_NUM_REGS 32

`endif

// File: source/cpu_pkg.sv
package cpu_pkg;

    // alu operations left in the subset
    typedef enum logic [3:0]
    {
        alu_add,    // add.w, addi.w
        alu_sub,
        alu_slt,    // signed compare
        alu_sltu,   // unsigned compare
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_lui     // lu12i.w, operand 2 passes through
    } alu_op_e;

    // fetch -> decode
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    // decode -> execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rj_value;
        logic [31:0] rkd_value;     // rk, or rd for branches
        logic [31:0] imm;
        logic [4:0]  dest;
        logic        gr_we;
        alu_op_e     alu_op;
        logic        src2_is_imm;
    } ds_to_es_t;

    // execute -> writeback
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        gr_we;
        logic [31:0] result;
    } es_to_ws_t;

    // writeback -> register file in decode
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    // in-flight destination seen by the interlock
    typedef struct packed {
        logic       we;
        logic [4:0] dest;
    } hazard_dest_t;

    // decode -> fetch redirect
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_t;

endpackage

// File: source/fetch_stage.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_allow_in,
    input  br_t         br,
    output logic        fs_to_ds_valid,
    output fs_to_ds_t   fs_to_ds,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata
);

    logic [`CPU_XLEN-1:0] fetch_pc;     // pc of the word now on rdata
    logic [`CPU_XLEN-1:0] seq_pc;
    logic [`CPU_XLEN-1:0] next_pc;
    logic                 fs_valid;
    logic                 fetch_req;

    assign seq_pc  = fetch_pc + 32'd4;
    assign next_pc = br.taken ? br.target : seq_pc;    // redirect wins

    // request whenever decode has room after reset
    assign fetch_req = !reset && ds_allow_in;

    always_ff @(posedge clk)
    begin
        if (reset)
            fetch_pc <= `CPU_RESET_PC;
        else if (fetch_req)
            fetch_pc <= next_pc;            // pc moves together with the request
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            fs_valid <= 1'b0;
        else if (ds_allow_in)
            fs_valid <= 1'b1;               // first word lands one cycle later
    end

    assign inst_sram_en   = fetch_req;
    assign inst_sram_addr = next_pc;

    // memory holds rdata while en is low so a stalled word stays put
    assign fs_to_ds_valid = fs_valid;
    assign fs_to_ds.inst  = inst_sram_rdata;
    assign fs_to_ds.pc    = fetch_pc;

    // branch targets and sequential pcs stay word aligned
    a_aligned_fetch: assert property (@(posedge clk) disable iff (reset)
        inst_sram_en |-> (inst_sram_addr[1:0] == 2'b00));

endmodule

// File: source/regfile.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module regfile
(
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [`CPU_XLEN-1:0] rf [`CPU_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (we && (waddr != 5'd0))
            rf[waddr] <= wdata;     // r0 write dropped here
    end

    // combinational read, r0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         fs_to_ds_valid,
    input  fs_to_ds_t    fs_to_ds,
    output logic         ds_allow_in,
    input  logic         es_allow_in,
    output logic         ds_to_es_valid,
    output ds_to_es_t    ds_to_es,
    input  hazard_dest_t es_to_ds,
    input  rf_write_t    ws_to_ds,
    output br_t          br
);

    fs_to_ds_t   ds_in;         // latched fetch word and pc
    logic        ds_valid;
    logic        ds_ready_go;
    logic [31:0] inst;
    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        rr_group;
    logic        inst_rr;
    logic        inst_addi_w;
    logic        inst_lu12i_w;
    logic        inst_b;
    logic        inst_beq;
    logic        inst_bne;
    logic        read_rj;
    logic        read_r2;
    logic [4:0]  rf_raddr2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] br_offs;
    logic        es_hit;
    logic        ws_hit;
    alu_op_e     alu_op;

    always_ff @(posedge clk)
    begin
        if (reset)
            ds_valid <= 1'b0;
        else if (br.taken)
            ds_valid <= 1'b0;               // drop the word fetched behind the branch
        else if (ds_allow_in)
            ds_valid <= fs_to_ds_valid;
    end

    always_ff @(posedge clk)
    begin
        if (fs_to_ds_valid && ds_allow_in)
            ds_in <= fs_to_ds;
    end

    assign inst     = ds_in.inst;
    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};    // b keeps its offset halves swapped

    // 3R format with only the eight kept funct codes known
    assign rr_group     = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign inst_rr      = rr_group && (op_19_15 inside {5'h00, 5'h02, 5'h04, 5'h05,
                                                        5'h08, 5'h09, 5'h0a, 5'h0b});
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    always_comb
    begin
        alu_op = alu_add;                   // addi.w, branches, unknown
        if (inst_lu12i_w)
            alu_op = alu_lui;
        else if (rr_group)
        begin
            case (op_19_15)
                5'h02:   alu_op = alu_sub;
                5'h04:   alu_op = alu_slt;
                5'h05:   alu_op = alu_sltu;
                5'h08:   alu_op = alu_nor;
                5'h09:   alu_op = alu_and;
                5'h0a:   alu_op = alu_or;
                5'h0b:   alu_op = alu_xor;
                default: alu_op = alu_add;
            endcase
        end
    end

    // beq/bne compare rj with rd so port 2 switches to rd
    assign rf_raddr2 = (inst_beq || inst_bne) ? rd : rk;
    assign read_rj   = inst_rr || inst_addi_w || inst_beq || inst_bne;
    assign read_r2   = inst_rr || inst_beq || inst_bne;

    regfile u_regfile
    (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (ws_to_ds.we),
        .waddr  (ws_to_ds.waddr),
        .wdata  (ws_to_ds.wdata)
    );

    // raw interlock against execute and writeback
    assign es_hit = es_to_ds.we && (es_to_ds.dest != 5'd0)     // r0 never blocks
                    && ((read_rj && (rj == es_to_ds.dest))
                        || (read_r2 && (rf_raddr2 == es_to_ds.dest)));
    assign ws_hit = ws_to_ds.we && (ws_to_ds.waddr != 5'd0)
                    && ((read_rj && (rj == ws_to_ds.waddr))
                        || (read_r2 && (rf_raddr2 == ws_to_ds.waddr)));

    assign ds_ready_go    = !(es_hit || ws_hit);
    assign ds_allow_in    = !ds_valid || (ds_ready_go && es_allow_in);
    assign ds_to_es_valid = ds_valid && ds_ready_go;    // bubble while stalled

    assign br_offs   = inst_b ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
    assign br.target = ds_in.pc + br_offs;
    assign br.taken  = ds_valid && ds_ready_go
                       && ((inst_beq && (rj_value == rkd_value))
                           || (inst_bne && (rj_value != rkd_value))
                           || inst_b);

    always_comb
    begin
        ds_to_es.pc          = ds_in.pc;
        ds_to_es.rj_value    = rj_value;
        ds_to_es.rkd_value   = rkd_value;
        ds_to_es.imm         = inst_lu12i_w ? {i20, 12'b0} : {{20{i12[11]}}, i12};
        ds_to_es.dest        = rd;
        ds_to_es.gr_we       = inst_rr || inst_addi_w || inst_lu12i_w;   // unknown never writes
        ds_to_es.alu_op      = alu_op;
        ds_to_es.src2_is_imm = inst_addi_w || inst_lu12i_w;
    end

    // a redirect always finds fetch ready to move
    a_taken_moves: assert property (@(posedge clk) disable iff (reset)
        br.taken |-> ds_allow_in);
    // at most two older writers in flight can hold decode
    a_stall_bounded: assert property (@(posedge clk) disable iff (reset)
        (ds_valid && !ds_ready_go && $past(ds_valid && !ds_ready_go)) |=> ds_ready_go);

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module execute_stage import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ds_to_es_valid,
    input  ds_to_es_t    ds_to_es,
    output logic         es_allow_in,
    input  logic         ws_allow_in,
    output logic         es_to_ws_valid,
    output es_to_ws_t    es_to_ws,
    output hazard_dest_t es_to_ds
);

    ds_to_es_t            es_in;
    logic                 es_valid;
    logic [`CPU_XLEN-1:0] alu_src1;
    logic [`CPU_XLEN-1:0] alu_src2;
    logic [`CPU_XLEN-1:0] alu_result;

    // single cycle alu, never holds anything back
    assign es_allow_in    = !es_valid || ws_allow_in;
    assign es_to_ws_valid = es_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
            es_valid <= 1'b0;
        else if (es_allow_in)
            es_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allow_in)
            es_in <= ds_to_es;
    end

    assign alu_src1 = es_in.rj_value;
    assign alu_src2 = es_in.src2_is_imm ? es_in.imm : es_in.rkd_value;  // si12 or si20<<12

    always_comb
    begin
        case (es_in.alu_op)
            alu_add:  alu_result = alu_src1 + alu_src2;
            alu_sub:  alu_result = alu_src1 - alu_src2;
            alu_slt:  alu_result = {{(`CPU_XLEN-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
            alu_sltu: alu_result = {{(`CPU_XLEN-1){1'b0}}, alu_src1 < alu_src2};
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_lui:  alu_result = alu_src2;                // imm already shifted in decode
            default:  alu_result = alu_src1 + alu_src2;
        endcase
    end

    always_comb
    begin
        es_to_ws.pc     = es_in.pc;
        es_to_ws.dest   = es_in.dest;
        es_to_ws.gr_we  = es_in.gr_we;
        es_to_ws.result = alu_result;
        es_to_ds.we     = es_valid && es_in.gr_we;     // empty stage never blocks decode
        es_to_ds.dest   = es_in.dest;
    end

endmodule

// File: source/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        es_to_ws_valid,
    input  es_to_ws_t   es_to_ws,
    output logic        ws_allow_in,
    output rf_write_t   ws_to_ds,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    es_to_ws_t ws_in;
    logic      ws_valid;

    assign ws_allow_in = 1'b1;      // last stage drains every cycle

    always_ff @(posedge clk)
    begin
        if (reset)
            ws_valid <= 1'b0;
        else
            ws_valid <= es_to_ws_valid;
    end

    always_ff @(posedge clk)
    begin
        if (es_to_ws_valid)
            ws_in <= es_to_ws;
    end

    // register file write, also the interlock source for decode
    assign ws_to_ds.we    = ws_valid && ws_in.gr_we;
    assign ws_to_ds.waddr = ws_in.dest;
    assign ws_to_ds.wdata = ws_in.result;

    // trace port
    assign debug_wb_pc       = ws_in.pc;
    assign debug_wb_rf_we    = {4{ws_to_ds.we}};
    assign debug_wb_rf_wnum  = ws_in.dest;
    assign debug_wb_rf_wdata = ws_in.result;

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
(
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    // handshake between neighbours
    logic                  fs_to_ds_valid;
    logic                  ds_allow_in;
    logic                  ds_to_es_valid;
    logic                  es_allow_in;
    logic                  es_to_ws_valid;
    logic                  ws_allow_in;

    // stage payloads and back buses
    cpu_pkg::fs_to_ds_t    fs_to_ds;
    cpu_pkg::ds_to_es_t    ds_to_es;
    cpu_pkg::es_to_ws_t    es_to_ws;
    cpu_pkg::hazard_dest_t es_to_ds;
    cpu_pkg::rf_write_t    ws_to_ds;
    cpu_pkg::br_t          br;

    fetch_stage u_fetch
    (
        .clk             (clk),
        .reset           (reset),
        .ds_allow_in     (ds_allow_in),
        .br              (br),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds        (fs_to_ds),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata)
    );

    decode_stage u_decode
    (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allow_in    (ds_allow_in),
        .es_allow_in    (es_allow_in),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_to_ds       (es_to_ds),
        .ws_to_ds       (ws_to_ds),
        .br             (br)
    );

    execute_stage u_execute
    (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allow_in    (es_allow_in),
        .ws_allow_in    (ws_allow_in),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws       (es_to_ws),
        .es_to_ds       (es_to_ds)
    );

    writeback_stage u_writeback
    (
        .clk               (clk),
        .reset             (reset),
        .es_to_ws_valid    (es_to_ws_valid),
        .es_to_ws          (es_to_ws),
        .ws_allow_in       (ws_allow_in),
        .ws_to_ds          (ws_to_ds),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;                // released just after the edge
    end

endmodule

// File: test/tb_checker.sv
`timescale 1ns/1ns

module tb_checker
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] timeout_cycles,
    input  logic [31:0] debug_wb_pc,
    input  logic [3:0]  debug_wb_rf_we,
    input  logic [4:0]  debug_wb_rf_wnum,
    input  logic [31:0] debug_wb_rf_wdata,
    output logic        done,
    output int          error_count
);

    // one expected trace write
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } trace_entry_t;

    trace_entry_t exp_q [$];        // filled by the model in program order
    int           cycle_count;
    int           quiet_cycles;     // cycles since the queue ran dry
    int           seen_count;
    int           mismatch_count;
    int           extra_count;
    int           other_count;      // hang or enable during reset
    logic         drained;

    task automatic push_expected(input logic [31:0] pc, input logic [4:0] num,
                                 input logic [31:0] data);
        trace_entry_t entry;
        entry.pc   = pc;
        entry.num  = num;
        entry.data = data;
        exp_q.push_back(entry);
    endtask

    task automatic compare_write;
        trace_entry_t exp;
        exp = exp_q.pop_front();
        seen_count++;
        if (debug_wb_rf_we !== 4'hf)    // all four byte enables or none
        begin
            $display("Error: debug_wb_rf_we = 0x%h, expected 0xf", debug_wb_rf_we);
            mismatch_count++;
        end
        if (debug_wb_pc !== exp.pc)
        begin
            $display("Error: debug_wb_pc = 0x%08h, expected 0x%08h", debug_wb_pc, exp.pc);
            mismatch_count++;
        end
        if (debug_wb_rf_wnum !== exp.num)
        begin
            $display("Error: debug_wb_rf_wnum = 0x%02h, expected 0x%02h (pc 0x%08h)",
                     debug_wb_rf_wnum, exp.num, exp.pc);
            mismatch_count++;
        end
        if (debug_wb_rf_wdata !== exp.data)
        begin
            $display("Error: debug_wb_rf_wdata = 0x%08h, expected 0x%08h (pc 0x%08h)",
                     debug_wb_rf_wdata, exp.data, exp.pc);
            mismatch_count++;
        end
    endtask

    initial
    begin
        done           = 1'b0;
        error_count    = 0;
        cycle_count    = 0;
        quiet_cycles   = 0;
        seen_count     = 0;
        mismatch_count = 0;
        extra_count    = 0;
        other_count    = 0;
    end

    // trace outputs come straight from writeback flops
    always @(posedge clk)
    begin
        if (!done)
        begin
            cycle_count++;
            drained = (exp_q.size() == 0);
            if (reset && (debug_wb_rf_we != 4'h0))
            begin
                $display("trace write enable was high while reset was asserted");
                other_count++;
            end
            else if (!reset && (debug_wb_rf_we != 4'h0))
            begin
                if (drained)
                begin
                    $display("unexpected extra register write at pc 0x%08h", debug_wb_pc);
                    extra_count++;
                end
                else
                    compare_write();
            end
            if (!reset && drained)
                quiet_cycles++;
            if ((quiet_cycles >= 20) || (cycle_count >= timeout_cycles))
            begin
                if (exp_q.size() != 0)
                begin
                    $display("run hung, %0d expected writes missing after %0d cycles",
                             exp_q.size(), cycle_count);
                    other_count++;
                end
                error_count = mismatch_count + extra_count + other_count;
                $display("trace check: %0d writes, %0d mismatches, %0d extra, %0d other errors",
                         seen_count, mismatch_count, extra_count, other_count);
                done = 1'b1;
            end
        end
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    localparam int          prog_len      = 200;
    localparam logic [31:0] text_base     = 32'h1C000000;   // first fetch address
    localparam int          timeout_limit = prog_len * 8 + 100;

    typedef enum int {k_rr, k_addi, k_lu12i, k_beq, k_bne, k_b} inst_kind_e;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        fetch_req_q;
    logic [31:0] fetch_addr_q;
    logic        checker_done;
    int          checker_errors;
    int unsigned seed_dummy;

    // program fields, encoded words and model registers
    inst_kind_e  kind      [prog_len];
    logic [4:0]  funct     [prog_len];
    logic [4:0]  rd        [prog_len];
    logic [4:0]  rj        [prog_len];
    logic [4:0]  rk        [prog_len];
    logic [25:0] imm       [prog_len];      // si12, si20 or branch word offset
    logic [31:0] prog_word [prog_len];
    logic [31:0] model_regs [32];
    logic [4:0]  rr_functs [8] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};

    tb_clock u_clock
    (
        .clk   (clk),
        .reset (reset)
    );

    cpu_top u_cpu_top
    (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_checker u_checker
    (
        .clk               (clk),
        .reset             (reset),
        .timeout_cycles    (32'(timeout_limit)),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done              (checker_done),
        .error_count       (checker_errors)
    );

    // mostly r0..r7 so hazards pile up
    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = 5'($urandom % 32);
        if (($urandom % 8) != 0)
            r = {2'b00, r[2:0]};
        return r;
    endfunction

    function automatic logic [31:0] encode_inst(input int i);
        case (kind[i])
            k_rr:    return {6'h00, 4'h0, 2'h1, funct[i], rk[i], rj[i], rd[i]};
            k_addi:  return {6'h00, 4'ha, imm[i][11:0], rj[i], rd[i]};
            k_lu12i: return {6'h05, 1'b0, imm[i][19:0], rd[i]};
            k_beq:   return {6'h16, imm[i][15:0], rj[i], rd[i]};
            k_bne:   return {6'h17, imm[i][15:0], rj[i], rd[i]};
            default: return {6'h14, imm[i][15:0], imm[i][25:16]};  // b with halves swapped
        endcase
    endfunction

    function automatic logic [31:0] rr_result(input logic [4:0] f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            5'h00:   return a + b;
            5'h02:   return a - b;
            5'h04:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            5'h05:   return (a < b) ? 32'd1 : 32'd0;
            5'h08:   return ~(a | b);
            5'h09:   return a & b;
            5'h0a:   return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic build_program;
        int unsigned pick;
        int unsigned span;
        int unsigned sel;
        for (int i = 0; i < prog_len; i++)
        begin
            pick     = $urandom % 16;
            sel      = $urandom % 8;
            rd[i]    = pick_reg();
            rj[i]    = pick_reg();
            rk[i]    = pick_reg();
            imm[i]   = 26'($urandom);
            funct[i] = rr_functs[sel[2:0]];
            if (i == prog_len - 1)
            begin
                kind[i] = k_b;              // b 0 loops on itself at the end
                imm[i]  = 26'd0;
            end
            else if (i < 31)
            begin
                // prologue gives r1..r31 a known value before any read
                kind[i] = (i % 2 == 0) ? k_lu12i : k_addi;
                rd[i]   = 5'(i + 1);
                rj[i]   = 5'd0;
            end
            else
            begin
                span = prog_len - 1 - i;
                if (span > 8)
                    span = 8;
                if (pick < 8)
                    kind[i] = k_rr;
                else if (pick < 11)
                    kind[i] = k_addi;
                else if (pick < 13)
                    kind[i] = k_lu12i;
                else if (pick == 13)
                    kind[i] = k_beq;
                else if (pick == 14)
                    kind[i] = k_bne;
                else
                    kind[i] = k_b;
                if (kind[i] inside {k_beq, k_bne, k_b})
                    imm[i] = 26'(1 + ($urandom % span));    // forward only and inside the program
            end
            prog_word[i] = encode_inst(i);
        end
    endtask

    task automatic retire_write(input int idx, input logic [31:0] value);
        if (rd[idx] != 5'd0)
            model_regs[rd[idx]] = value;    // r0 stays zero but the trace still shows it
        u_checker.push_expected(text_base + 32'(idx * 4), rd[idx], value);
    endtask

    // isa model stepping one instruction at a time in program order
    task automatic run_model;
        logic [31:0] a;
        logic [31:0] b;
        int          idx;
        for (int r = 0; r < 32; r++)
            model_regs[r] = 32'h0;
        idx = 0;
        while (idx < prog_len - 1)
        begin
            a = model_regs[rj[idx]];
            b = (kind[idx] == k_rr) ? model_regs[rk[idx]] : model_regs[rd[idx]];
            case (kind[idx])
                k_rr:    retire_write(idx, rr_result(funct[idx], a, b));
                k_addi:  retire_write(idx, a + {{20{imm[idx][11]}}, imm[idx][11:0]});
                k_lu12i: retire_write(idx, {imm[idx][19:0], 12'h000});
                default: ;
            endcase
            if ((kind[idx] == k_b) || ((kind[idx] == k_beq) && (a == b))
                || ((kind[idx] == k_bne) && (a != b)))
                idx = idx + int'(imm[idx]);
            else
                idx = idx + 1;
        end
    endtask

    // unknown opcode 0x3f outside the program
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] offs;
        int          idx;
        offs = addr - text_base;
        idx  = int'(offs[31:2]);
        if ((offs < 32'(prog_len * 4)) && (addr[1:0] == 2'b00))
            return prog_word[idx];
        return {6'h3f, addr[25:0] ^ addr[31:6]};
    endfunction

    always @(negedge clk)
    begin
        fetch_req_q  <= inst_sram_en;       // request seen mid-cycle
        fetch_addr_q <= inst_sram_addr;
    end

    // word returns one cycle after the request and holds while en is low
    always @(posedge clk)
    begin
        #1;
        if (fetch_req_q)
            inst_sram_rdata = mem_word(fetch_addr_q);
    end

    initial
    begin
        inst_sram_rdata = 32'h0;
        fetch_req_q     = 1'b0;
        fetch_addr_q    = 32'h0;
        seed_dummy      = $urandom(62713);
        build_program();
        run_model();
        wait (checker_done);
        if (checker_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: list.f
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -f list.f --Mdir obj_dir -o tb_sim
	out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
